// File: src/pe_tx_pkg.sv
// tx protocol engine definitions
package pe_tx_pkg;

// ============================================================
// widths
// ============================================================

// mii data bus, one nibble per clock
localparam int NIBBLE_W = 4;
localparam int BYTE_W   = 8;
// payload length field of the descriptor
localparam int LEN_W    = 12;
// preamble byte count, sfd included
localparam int PRE_W    = 4;
// extra gap bytes from the register config
localparam int GAP_W    = 6;

// ============================================================
// frame constants
// ============================================================

// payload plus pad, fcs not counted
localparam logic [LEN_W-1:0] MIN_FRAME_BYTES = LEN_W'(60);
localparam int FCS_BYTES = 4;
// fixed part of the inter-frame gap
localparam logic [GAP_W:0] GAP_BASE_BYTES = (GAP_W + 1)'(5);
localparam logic [BYTE_W-1:0] PREAMBLE_BYTE = 8'h55;
localparam logic [BYTE_W-1:0] SFD_BYTE = 8'hd5;
// ieee 802.3 crc, reflected form
localparam logic [31:0] CRC_INIT = 32'hffff_ffff;
localparam logic [31:0] CRC_POLY_REFL = 32'hedb8_8320;

// ============================================================
// types
// ============================================================

// per-frame descriptor, sampled with start
typedef struct packed {
	logic [LEN_W-1:0] payload_len;
	logic             crc_en;
	logic             pad_en;
} tx_desc_t;

// register config
typedef struct packed {
	logic [PRE_W-1:0] pre_bytes;
	logic [GAP_W-1:0] gap_bytes;
} tx_cfg_t;

// decoded frame, held by the sequencer for the whole frame
typedef struct packed {
	logic [PRE_W-1:0] pre_bytes;
	logic [LEN_W-1:0] payload_len;
	logic [5:0]       pad_len;
	logic             crc_en;
	logic [GAP_W:0]   gap_total;
} frame_plan_t;

// field of the nibble being sent
typedef enum logic [2:0] {
	FIELD_NONE,
	FIELD_PREAMBLE,
	FIELD_SFD,
	FIELD_PAYLOAD,
	FIELD_PAD,
	FIELD_FCS,
	FIELD_GAP
} tx_field_e;

// control for one nibble, one cycle ahead of tx_data
typedef struct packed {
	tx_field_e  field;
	logic       hi_nibble;
	logic [1:0] fcs_index;
	logic       crc_upd;
	logic       crc_clr;
} nibble_ctl_t;

endpackage

// File: src/crc32_d8.sv
// byte-wide crc-32
`timescale 1ns/1ns

module crc32_d8
(
	input  logic                         pe_tx_clk,
	input  logic                         pe_tx_rstn,
	input  logic                         clr,
	input  logic                         upd,
	input  logic [pe_tx_pkg::BYTE_W-1:0] data,
	output logic [31:0]                  crc
);

logic [31:0] crc_nxt;

// ============================================================
// reflected update, lsb first
// ============================================================

always_comb
begin
	// fold the byte into the low end
	crc_nxt = crc ^ {24'd0, data};
	// eight shift steps, one per data bit
	for (int i = 0; i < pe_tx_pkg::BYTE_W; i++)
	begin
		if (crc_nxt[0])
			crc_nxt = (crc_nxt >> 1) ^ pe_tx_pkg::CRC_POLY_REFL;
		else
			crc_nxt = crc_nxt >> 1;
	end
end

// remainder, not inverted here
always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
		crc <= pe_tx_pkg::CRC_INIT;
	else if (clr)
		crc <= pe_tx_pkg::CRC_INIT;
	else if (upd)
		crc <= crc_nxt;
end

endmodule

// File: src/frame_cfg_decode.sv
// frame config decode
`timescale 1ns/1ns

module frame_cfg_decode
(
	input  logic                   pe_tx_clk,
	input  logic                   pe_tx_rstn,
	input  logic                   start,
	input  pe_tx_pkg::tx_desc_t    desc,
	input  pe_tx_pkg::tx_cfg_t     cfg,
	output pe_tx_pkg::frame_plan_t plan,
	output logic                   plan_valid
);

// ============================================================
// padding and gap
// ============================================================

logic                        pad_real;
logic [pe_tx_pkg::LEN_W-1:0] pad_full;

// pad only short frames, and only with hw crc on
// pad without crc is not supported
assign pad_real = desc.pad_en && desc.crc_en
	&& (desc.payload_len < pe_tx_pkg::MIN_FRAME_BYTES);

// bytes missing up to the minimum
// fits in 6 bits whenever pad_real is set
assign pad_full = pe_tx_pkg::MIN_FRAME_BYTES - desc.payload_len;

// ============================================================
// plan register
// ============================================================

always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
	begin
		plan       <= '0;
		plan_valid <= 1'b0;
	end
	else
	begin
		// one cycle strobe behind start
		plan_valid <= start;
		// busy filtering happens in the sequencer
		if (start)
		begin
			plan.pre_bytes   <= cfg.pre_bytes;
			plan.payload_len <= desc.payload_len;
			plan.pad_len     <= pad_real ? pad_full[5:0] : 6'd0;
			plan.crc_en      <= desc.crc_en;
			// base gap plus configured extra
			plan.gap_total   <= pe_tx_pkg::GAP_BASE_BYTES + {1'b0, cfg.gap_bytes};
		end
	end
end

endmodule

// File: src/frame_sequencer.sv
// tx frame sequencer
`timescale 1ns/1ns

module frame_sequencer
(
	input  logic                   pe_tx_clk,
	input  logic                   pe_tx_rstn,
	input  logic                   pe_tx_logic_clr,
	input  logic                   plan_valid,
	input  pe_tx_pkg::frame_plan_t plan,
	output pe_tx_pkg::nibble_ctl_t ctl,
	output logic                   byte_rd,
	output logic                   load_byte,
	output logic                   busy
);

// one-hot frame states
typedef struct packed {
	logic idle;
	logic pre;
	logic pay;
	logic pad;
	logic fcs;
	logic gap;
	logic fin;
} seq_state_t;

seq_state_t                  st;
seq_state_t                  st_nxt;
pe_tx_pkg::frame_plan_t      plan_q;
pe_tx_pkg::frame_plan_t      pl;
logic                        go;
logic                        in_pre;
logic                        in_frame;
logic                        phase;
logic                        end_q;
logic                        has_pad;
logic [pe_tx_pkg::PRE_W-1:0] pre_cnt;
logic [pe_tx_pkg::LEN_W-1:0] pay_cnt;
logic [5:0]                  pad_cnt;
logic [1:0]                  fcs_cnt;
logic [pe_tx_pkg::GAP_W:0]   gap_cnt;
logic                        pre_last;
logic                        pay_last;
logic                        pad_last;
logic                        fcs_last;
logic                        gap_last;
logic                        pre_done;
logic                        pay_done;
logic                        pad_done;
logic                        fcs_done;
logic                        gap_done;

// ============================================================
// frame start and field ends
// ============================================================

// starts while not idle are dropped
assign go = st.idle && plan_valid && !pe_tx_logic_clr;
// the accept cycle already issues the first preamble nibble
assign in_pre = st.pre || go;
assign in_frame = in_pre || st.pay || st.pad || st.fcs || st.gap;
// live plan on the accept cycle, held copy afterwards
assign pl = st.idle ? plan : plan_q;
assign has_pad = |pl.pad_len;

assign pre_last = pre_cnt == pl.pre_bytes - 1'b1;
assign pay_last = pay_cnt == pl.payload_len - 1'b1;
assign pad_last = pad_cnt == pl.pad_len - 1'b1;
assign fcs_last = fcs_cnt == 2'(pe_tx_pkg::FCS_BYTES - 1);
assign gap_last = gap_cnt == pl.gap_total - 1'b1;

// a field ends on the high nibble of its last byte
assign pre_done = st.pre && phase && pre_last;
assign pay_done = st.pay && phase && pay_last;
assign pad_done = st.pad && phase && pad_last;
assign fcs_done = st.fcs && phase && fcs_last;
assign gap_done = st.gap && phase && gap_last;

// ============================================================
// state machine
// ============================================================

always_comb
begin
	st_nxt.idle = pe_tx_logic_clr || (st.idle && !go) || st.fin;
	st_nxt.pre  = !pe_tx_logic_clr && (go || (st.pre && !pre_done));
	st_nxt.pay  = !pe_tx_logic_clr && (pre_done || (st.pay && !pay_done));
	st_nxt.pad  = !pe_tx_logic_clr && ((pay_done && has_pad) || (st.pad && !pad_done));
	// fcs after pad, or straight after payload
	st_nxt.fcs  = !pe_tx_logic_clr && ((pay_done && !has_pad && pl.crc_en)
		|| pad_done || (st.fcs && !fcs_done));
	st_nxt.gap  = !pe_tx_logic_clr && ((pay_done && !has_pad && !pl.crc_en)
		|| fcs_done || (st.gap && !gap_done));
	st_nxt.fin  = !pe_tx_logic_clr && gap_done;
end

always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
	begin
		st    <= '{idle: 1'b1, default: 1'b0};
		phase <= 1'b0;
		end_q <= 1'b0;
	end
	else
	begin
		st    <= st_nxt;
		// low nibble first, every field ends on a high nibble
		phase <= in_frame && !pe_tx_logic_clr && !phase;
		end_q <= st.fin && !pe_tx_logic_clr;
	end
end

// plan copy, later starts may overwrite the decoder output
always_ff @(posedge pe_tx_clk)
begin
	if (go)
		plan_q <= plan;
end

// ============================================================
// byte counters, one per field
// ============================================================

always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
	begin
		pre_cnt <= '0;
		pay_cnt <= '0;
		pad_cnt <= '0;
		fcs_cnt <= '0;
		gap_cnt <= '0;
	end
	else
	begin
		// preamble bytes, sfd is the last one
		if (pe_tx_logic_clr || pre_done)
			pre_cnt <= '0;
		else if (in_pre && phase)
			pre_cnt <= pre_cnt + 1'b1;
		if (pe_tx_logic_clr || pay_done)
			pay_cnt <= '0;
		else if (st.pay && phase)
			pay_cnt <= pay_cnt + 1'b1;
		if (pe_tx_logic_clr || pad_done)
			pad_cnt <= '0;
		else if (st.pad && phase)
			pad_cnt <= pad_cnt + 1'b1;
		// doubles as the fcs byte index
		if (pe_tx_logic_clr || fcs_done)
			fcs_cnt <= '0;
		else if (st.fcs && phase)
			fcs_cnt <= fcs_cnt + 1'b1;
		if (pe_tx_logic_clr || gap_done)
			gap_cnt <= '0;
		else if (st.gap && phase)
			gap_cnt <= gap_cnt + 1'b1;
	end
end

// ============================================================
// nibble control and byte source
// ============================================================

always_comb
begin
	if (in_pre && pre_last)
		ctl.field = pe_tx_pkg::FIELD_SFD;
	else if (in_pre)
		ctl.field = pe_tx_pkg::FIELD_PREAMBLE;
	else if (st.pay)
		ctl.field = pe_tx_pkg::FIELD_PAYLOAD;
	else if (st.pad)
		ctl.field = pe_tx_pkg::FIELD_PAD;
	else if (st.fcs)
		ctl.field = pe_tx_pkg::FIELD_FCS;
	else if (st.gap)
		ctl.field = pe_tx_pkg::FIELD_GAP;
	else
		ctl.field = pe_tx_pkg::FIELD_NONE;
	ctl.hi_nibble = phase;
	ctl.fcs_index = fcs_cnt;
	// crc takes whole bytes on the high nibble
	ctl.crc_upd   = (st.pay || st.pad) && phase && pl.crc_en;
	ctl.crc_clr   = go;
end

// request after the low nibble of sfd or of a non-last payload byte
// so the next byte is on byte_data when its low nibble is issued
always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
		byte_rd <= 1'b0;
	else
		byte_rd <= !pe_tx_logic_clr && !phase
			&& ((in_pre && pre_last) || (st.pay && !pay_last));
end

// driver keeps the byte for its high nibble and the crc
assign load_byte = st.pay && !phase;

// held through the done cycle
assign busy = go || !st.idle || end_q;

endmodule

// File: src/mii_tx_driver.sv
// mii transmit driver
`timescale 1ns/1ns

module mii_tx_driver
(
	input  logic                           pe_tx_clk,
	input  logic                           pe_tx_rstn,
	input  logic                           pe_tx_logic_clr,
	input  pe_tx_pkg::nibble_ctl_t         ctl,
	input  logic                           load_byte,
	input  logic [pe_tx_pkg::BYTE_W-1:0]   byte_data,
	output logic [pe_tx_pkg::NIBBLE_W-1:0] tx_data,
	output logic                           tx_en,
	output logic                           done
);

logic [pe_tx_pkg::BYTE_W-1:0]   byte_q;
logic [pe_tx_pkg::BYTE_W-1:0]   crc_data;
logic [pe_tx_pkg::BYTE_W-1:0]   sel_byte;
logic [pe_tx_pkg::NIBBLE_W-1:0] nib;
logic                           nib_valid;
logic                           gap_q;
logic [31:0]                    crc_rem;
logic [31:0]                    fcs_word;

// ============================================================
// payload byte and crc
// ============================================================

// current payload byte for the high nibble and the crc
always_ff @(posedge pe_tx_clk)
begin
	if (load_byte)
		byte_q <= byte_data;
end

// pad bytes enter the crc as zero
assign crc_data = (ctl.field == pe_tx_pkg::FIELD_PAD) ? '0 : byte_q;

crc32_d8 u_crc
(
	.pe_tx_clk  (pe_tx_clk),
	.pe_tx_rstn (pe_tx_rstn),
	.clr        (ctl.crc_clr || pe_tx_logic_clr),
	.upd        (ctl.crc_upd),
	.data       (crc_data),
	.crc        (crc_rem)
);

// fcs goes out inverted, lsb byte first
assign fcs_word = ~crc_rem;

// ============================================================
// nibble select
// ============================================================

always_comb
begin
	nib_valid = 1'b1;
	case (ctl.field)
	pe_tx_pkg::FIELD_PREAMBLE: sel_byte = pe_tx_pkg::PREAMBLE_BYTE;
	pe_tx_pkg::FIELD_SFD:      sel_byte = pe_tx_pkg::SFD_BYTE;
	// low nibble straight from the source, high from the latch
	pe_tx_pkg::FIELD_PAYLOAD:  sel_byte = ctl.hi_nibble ? byte_q : byte_data;
	pe_tx_pkg::FIELD_PAD:      sel_byte = '0;
	pe_tx_pkg::FIELD_FCS:
		sel_byte = fcs_word[{ctl.fcs_index, 3'b000} +: pe_tx_pkg::BYTE_W];
	default:
	begin
		// gap and idle
		sel_byte  = '0;
		nib_valid = 1'b0;
	end
	endcase
	nib = ctl.hi_nibble ? sel_byte[pe_tx_pkg::NIBBLE_W +: pe_tx_pkg::NIBBLE_W]
		: sel_byte[0 +: pe_tx_pkg::NIBBLE_W];
end

// ============================================================
// output registers
// ============================================================

always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
	begin
		tx_data <= '0;
		tx_en   <= 1'b0;
		gap_q   <= 1'b0;
		done    <= 1'b0;
	end
	else if (pe_tx_logic_clr)
	begin
		// abort, no done for this frame
		tx_data <= '0;
		tx_en   <= 1'b0;
		gap_q   <= 1'b0;
		done    <= 1'b0;
	end
	else
	begin
		tx_data <= nib_valid ? nib : '0;
		tx_en   <= nib_valid;
		gap_q   <= ctl.field == pe_tx_pkg::FIELD_GAP;
		// end state follows the last gap nibble
		done    <= gap_q && (ctl.field == pe_tx_pkg::FIELD_NONE);
	end
end

endmodule

// File: src/eth_mac_pe_tx.sv
// ethernet mac tx protocol engine
`timescale 1ns/1ns

module eth_mac_pe_tx
(
	input  logic                           pe_tx_clk,
	input  logic                           pe_tx_rstn,
	input  logic                           pe_tx_logic_clr,
	input  logic                           start,
	input  pe_tx_pkg::tx_desc_t            desc,
	input  pe_tx_pkg::tx_cfg_t             cfg,
	input  logic [pe_tx_pkg::BYTE_W-1:0]   byte_data,
	output logic                           byte_rd,
	output logic                           busy,
	output logic [pe_tx_pkg::NIBBLE_W-1:0] tx_data,
	output logic                           tx_en,
	output logic                           done
);

pe_tx_pkg::frame_plan_t plan;
logic                   plan_valid;
pe_tx_pkg::nibble_ctl_t ctl;
logic                   load_byte;

// ============================================================
// decode, sequence, drive
// ============================================================

// descriptor and config to a registered plan
frame_cfg_decode u_decode
(
	.pe_tx_clk  (pe_tx_clk),
	.pe_tx_rstn (pe_tx_rstn),
	.start      (start),
	.desc       (desc),
	.cfg        (cfg),
	.plan       (plan),
	.plan_valid (plan_valid)
);

// field fsm, one nibble of control per clock
frame_sequencer u_seq
(
	.pe_tx_clk       (pe_tx_clk),
	.pe_tx_rstn      (pe_tx_rstn),
	.pe_tx_logic_clr (pe_tx_logic_clr),
	.plan_valid      (plan_valid),
	.plan            (plan),
	.ctl             (ctl),
	.byte_rd         (byte_rd),
	.load_byte       (load_byte),
	.busy            (busy)
);

// mii nibble bus and fcs
mii_tx_driver u_drv
(
	.pe_tx_clk       (pe_tx_clk),
	.pe_tx_rstn      (pe_tx_rstn),
	.pe_tx_logic_clr (pe_tx_logic_clr),
	.ctl             (ctl),
	.load_byte       (load_byte),
	.byte_data       (byte_data),
	.tx_data         (tx_data),
	.tx_en           (tx_en),
	.done            (done)
);

endmodule

// File: tests/frame_checker.sv
// tx frame checker
`timescale 1ns/1ns

module frame_checker
(
	input logic                           pe_tx_clk,
	input logic                           pe_tx_rstn,
	input logic                           pe_tx_logic_clr,
	input logic                           start,
	input logic                           busy,
	input logic [pe_tx_pkg::NIBBLE_W-1:0] tx_data,
	input logic                           tx_en,
	input logic                           done
);

// expected frames, nibbles back to back
logic [3:0] exp_nib[$];
int         exp_len[$];
int         exp_gap[$];
bit         exp_abort[$];

logic [3:0] nib_exp;
int         cur_len = 0;
int         cur_gap = 0;
bit         cur_abort = 1'b0;
int         idx = 0;
// cycles since the last accepted start and since tx_en fell
int         since_start = 1000;
int         since_fall = 0;
bit         en_q = 1'b0;
bit         clr_q = 1'b0;
bit         wait_done = 1'b0;
// expected busy level for the current cycle
bit         busy_exp = 1'b0;
int         err_cnt = 0;
int         err_mark = 0;
int         pass_cnt = 0;
int         fail_cnt = 0;

// ============================================================
// expectations from the testbench
// ============================================================

task automatic push_nibble(input logic [3:0] n);
	exp_nib.push_back(n);
endtask

// length in nibbles, gap in cycles, abort marks a frame cut by clear
task automatic push_frame(input int len, input int gap, input bit abort);
	exp_len.push_back(len);
	exp_gap.push_back(gap);
	exp_abort.push_back(abort);
endtask

task automatic finish_test(input string name);
	if (exp_len.size() != 0 || wait_done || en_q)
	begin
		$display("error at %0t: test %s ended with a frame still outstanding", $time, name);
		err_cnt++;
	end
	if (err_cnt == err_mark)
	begin
		pass_cnt++;
		$display("test %s: pass", name);
	end
	else
	begin
		fail_cnt++;
		$display("test %s: fail, %0d errors", name, err_cnt - err_mark);
	end
	err_mark = err_cnt;
endtask

// ============================================================
// compare, sampled mid cycle
// ============================================================

always @(negedge pe_tx_clk)
begin
	if (pe_tx_rstn)
	begin
		// starts during busy are dropped by the dut
		if (start && !busy_exp)
			since_start = 0;
		else
			since_start++;
		since_fall++;

		// busy from the cycle after an accepted start to the cycle after done
		if (busy !== busy_exp)
		begin
			$display("mismatch at %0t: busy exp %0b got %0b", $time, busy_exp, busy);
			err_cnt++;
		end

		// frame start
		if (tx_en && !en_q)
		begin
			if (exp_len.size() == 0)
			begin
				$display("error at %0t: tx_en rose with no frame expected", $time);
				err_cnt++;
				cur_len   = 0;
				cur_gap   = 0;
				cur_abort = 1'b0;
			end
			else
			begin
				cur_len   = exp_len.pop_front();
				cur_gap   = exp_gap.pop_front();
				cur_abort = exp_abort.pop_front();
			end
			idx = 0;
			if (since_start != 2)
			begin
				$display("mismatch at %0t: tx_en rise delay exp %0d got %0d",
					$time, 2, since_start);
				err_cnt++;
			end
		end

		// one nibble per cycle while tx_en is high
		if (tx_en)
		begin
			if (idx < cur_len)
			begin
				nib_exp = exp_nib.pop_front();
				if (tx_data !== nib_exp)
				begin
					$display("mismatch at %0t: tx_data nibble %0d exp %h got %h",
						$time, idx, nib_exp, tx_data);
					err_cnt++;
				end
			end
			idx++;
		end

		// frame end
		if (!tx_en && en_q)
		begin
			if (cur_abort && !clr_q)
			begin
				$display("error at %0t: aborted frame ended without a clear", $time);
				err_cnt++;
			end
			else if (!cur_abort && idx != cur_len)
			begin
				$display("mismatch at %0t: tx_en cycles exp %0d got %0d",
					$time, cur_len, idx);
				err_cnt++;
			end
			// drop what an aborted frame never sent
			while (idx < cur_len)
			begin
				void'(exp_nib.pop_front());
				idx++;
			end
			wait_done  = !cur_abort;
			since_fall = 0;
		end

		if (done)
		begin
			if (!wait_done)
			begin
				$display("error at %0t: done pulsed with no frame pending", $time);
				err_cnt++;
			end
			else if (since_fall != cur_gap)
			begin
				$display("mismatch at %0t: done delay exp %0d got %0d",
					$time, cur_gap, since_fall);
				err_cnt++;
			end
			wait_done = 1'b0;
		end

		// busy level for the next cycle
		if (since_start == 0)
			busy_exp = 1'b1;
		else if (pe_tx_logic_clr || done)
			busy_exp = 1'b0;

		en_q  = tx_en;
		clr_q = pe_tx_logic_clr;
	end
end

endmodule

// File: tests/tb_eth_mac_pe_tx.sv
// tx protocol engine testbench
`timescale 1ns/1ns

module tb_eth_mac_pe_tx;

// ============================================================
// run limits
// ============================================================

localparam int NUM_FRAMES = 16;
// 15 preamble, 80 payload, fcs and the widest gap, in nibbles
localparam int FRAME_CYCLES_MAX = 2 * (15 + 80 + 4 + 5 + 63) + 8;
localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES_MAX + 400;

logic                   pe_tx_clk = 1'b0;
logic                   pe_tx_rstn = 1'b0;
logic                   pe_tx_logic_clr = 1'b0;
logic                   start = 1'b0;
pe_tx_pkg::tx_desc_t    desc = '0;
pe_tx_pkg::tx_cfg_t     cfg = '0;
logic [7:0]             byte_data = '0;
logic                   byte_rd;
logic                   busy;
logic [3:0]             tx_data;
logic                   tx_en;
logic                   done;

logic [31:0]            lfsr = 32'h14ad1f06;
logic [7:0]             pay_mem [0:127];
int                     rd_idx = 0;
// expected nibbles of the frame being set up
logic [3:0]             ref_nib[$];

always #5 pe_tx_clk = ~pe_tx_clk;

eth_mac_pe_tx dut0
(
	.pe_tx_clk       (pe_tx_clk),
	.pe_tx_rstn      (pe_tx_rstn),
	.pe_tx_logic_clr (pe_tx_logic_clr),
	.start           (start),
	.desc            (desc),
	.cfg             (cfg),
	.byte_data       (byte_data),
	.byte_rd         (byte_rd),
	.busy            (busy),
	.tx_data         (tx_data),
	.tx_en           (tx_en),
	.done            (done)
);

frame_checker chk
(
	.pe_tx_clk       (pe_tx_clk),
	.pe_tx_rstn      (pe_tx_rstn),
	.pe_tx_logic_clr (pe_tx_logic_clr),
	.start           (start),
	.busy            (busy),
	.tx_data         (tx_data),
	.tx_en           (tx_en),
	.done            (done)
);

// byte source, next byte one cycle after byte_rd
always @(posedge pe_tx_clk)
begin
	if (start && !busy)
		rd_idx <= 0;
	else if (byte_rd)
	begin
		byte_data <= pay_mem[rd_idx];
		rd_idx    <= rd_idx + 1;
	end
end

// ============================================================
// random numbers and reference model
// ============================================================

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken
function automatic int take_bits(input int n);
	int val;
	val = 0;
	for (int i = 0; i < n; i++)
	begin
		lfsr = lfsr_next(lfsr);
		val  = (val << 1) | int'(lfsr[0]);
	end
	return val;
endfunction

// serial crc-32, one data bit per step, lsb first
function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
	logic [31:0] r;
	r = c;
	for (int i = 0; i < 8; i++)
		r = (r[0] ^ b[i]) ? ((r >> 1) ^ 32'hedb8_8320) : (r >> 1);
	return r;
endfunction

// low nibble goes out first
function automatic void push_byte(input logic [7:0] b);
	ref_nib.push_back(b[3:0]);
	ref_nib.push_back(b[7:4]);
endfunction

// expected nibbles into ref_nib, returns the gap in cycles
function automatic int build_ref(input pe_tx_pkg::tx_desc_t d, input pe_tx_pkg::tx_cfg_t c);
	int          pad;
	logic [31:0] crc;
	logic [7:0]  b;
	ref_nib.delete();
	for (int i = 0; i < int'(c.pre_bytes) - 1; i++)
		push_byte(8'h55);
	push_byte(8'hd5);
	// pad only with crc on and a short payload
	pad = 0;
	if (d.pad_en && d.crc_en && d.payload_len < pe_tx_pkg::MIN_FRAME_BYTES)
		pad = int'(pe_tx_pkg::MIN_FRAME_BYTES) - int'(d.payload_len);
	crc = 32'hffff_ffff;
	for (int i = 0; i < int'(d.payload_len) + pad; i++)
	begin
		b = (i < int'(d.payload_len)) ? pay_mem[i] : 8'h00;
		push_byte(b);
		crc = crc_byte(crc, b);
	end
	// inverted remainder, lsb byte first
	if (d.crc_en)
		for (int i = 0; i < 4; i++)
			push_byte(~crc[8*i +: 8]);
	return 2 * (5 + int'(c.gap_bytes));
endfunction

// ============================================================
// frame stimulus
// ============================================================

task automatic launch(input int len, input bit crc_en, input bit pad_en,
	input int pre, input int gap, input bit abort);
	pe_tx_pkg::tx_desc_t d;
	pe_tx_pkg::tx_cfg_t  c;
	int                  gap_cyc;
	d.payload_len = 12'(len);
	d.crc_en      = crc_en;
	d.pad_en      = pad_en;
	c.pre_bytes   = 4'(pre);
	c.gap_bytes   = 6'(gap);
	for (int i = 0; i < len; i++)
		pay_mem[i] = 8'(take_bits(8));
	gap_cyc = build_ref(d, c);
	foreach (ref_nib[i])
		chk.push_nibble(ref_nib[i]);
	chk.push_frame(ref_nib.size(), gap_cyc, abort);
	@(posedge pe_tx_clk);
	desc  <= d;
	cfg   <= c;
	start <= 1'b1;
	@(posedge pe_tx_clk);
	start <= 1'b0;
endtask

task automatic wait_done();
	do
		@(posedge pe_tx_clk);
	while (!done);
endtask

task automatic send(input int len, input bit crc_en, input bit pad_en,
	input int pre, input int gap);
	launch(len, crc_en, pad_en, pre, gap, 1'b0);
	wait_done();
endtask

// ============================================================
// tests
// ============================================================

initial
begin
	int len;
	int gap;
	repeat (4) @(posedge pe_tx_clk);
	pe_tx_rstn <= 1'b1;
	repeat (2) @(posedge pe_tx_clk);

	// shortest, default and longest preamble
	len = 1 + take_bits(6) % 40;
	send(len, 1'b1, 1'b1, 2, 0);
	len = 1 + take_bits(6) % 40;
	send(len, 1'b1, 1'b1, 8, 0);
	len = 1 + take_bits(6) % 40;
	send(len, 1'b1, 1'b1, 15, 0);
	chk.finish_test("preamble");

	// long payloads, no fcs
	for (int i = 0; i < 3; i++)
	begin
		len = 60 + take_bits(5) % 21;
		gap = take_bits(3);
		send(len, 1'b0, take_bits(1) == 1, 8, gap);
	end
	chk.finish_test("payload");

	// short frames padded to the minimum
	for (int i = 0; i < 3; i++)
	begin
		len = 1 + take_bits(6) % 59;
		send(len, 1'b1, 1'b1, 8, 0);
	end
	// pad request without crc stays short
	len = 1 + take_bits(5);
	send(len, 1'b0, 1'b1, 8, 0);
	chk.finish_test("pad_fcs");

	// no extra gap, widest gap, random gap
	send(20, 1'b1, 1'b1, 8, 0);
	send(20, 1'b1, 1'b1, 8, 63);
	gap = take_bits(6);
	launch(30, 1'b1, 1'b0, 8, gap, 1'b0);
	do
		@(posedge pe_tx_clk);
	while (!tx_en);
	repeat (6) @(posedge pe_tx_clk);
	// second start mid frame, dropped by the dut
	desc.payload_len <= 12'd5;
	start            <= 1'b1;
	@(posedge pe_tx_clk);
	start <= 1'b0;
	wait_done();
	repeat (8) @(posedge pe_tx_clk);
	chk.finish_test("gap_done");

	// clear a few bytes into the payload
	launch(50, 1'b1, 1'b1, 8, 2, 1'b1);
	repeat (6)
	begin
		do
			@(posedge pe_tx_clk);
		while (!byte_rd);
	end
	pe_tx_logic_clr <= 1'b1;
	@(posedge pe_tx_clk);
	pe_tx_logic_clr <= 1'b0;
	do
		@(posedge pe_tx_clk);
	while (busy);
	// longer than the gap, so a late done would show up
	repeat (40) @(posedge pe_tx_clk);
	send(50, 1'b1, 1'b1, 8, 2);
	chk.finish_test("abort");

	$display("tests passed %0d failed %0d, errors %0d",
		chk.pass_cnt, chk.fail_cnt, chk.err_cnt);
	if (chk.fail_cnt == 0 && chk.err_cnt == 0)
		$display("TEST OK");
	else
		$display("TEST FAILED");
	$finish;
end

// hang guard
initial
begin
	repeat (WATCHDOG_CYCLES) @(posedge pe_tx_clk);
	$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
	$display("TEST FAILED");
	$finish;
end

endmodule

// File: list.f
src/pe_tx_pkg.sv
src/crc32_d8.sv
src/frame_cfg_decode.sv
src/frame_sequencer.sv
src/mii_tx_driver.sv
src/eth_mac_pe_tx.sv
tests/frame_checker.sv
tests/tb_eth_mac_pe_tx.sv

// File: Bender.yml
package:
  name: eth_mac_pe_tx

sources:
  # package first, then leaf modules, then the top level
  - src/pe_tx_pkg.sv
  - src/crc32_d8.sv
  - src/frame_cfg_decode.sv
  - src/frame_sequencer.sv
  - src/mii_tx_driver.sv
  - src/eth_mac_pe_tx.sv

  - target: test
    files:
      - tests/frame_checker.sv
      - tests/tb_eth_mac_pe_tx.sv
